// File: project.f
hw/ciPkg.sv
hw/resetSequencer.sv
hw/pixelCi.sv
hw/profileCounters.sv
hw/delayCi.sv
hw/ciSubsystem.sv
sim/ciSubsystem_checker.sv
sim/ciSubsystemTb.sv

// File: runSim.sh
#!/bin/bash
# Build and run the custom-instruction testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module ciSubsystemTb -f project.f --Mdir obj_dir -o simCiSubsystem

./obj_dir/simCiSubsystem +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
  exit 1
fi
if ! grep -q "all tests passed" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

// File: sim/ciSubsystemTb.sv
module ciSubsystemTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clockPeriod   = 4;
  localparam int ticksPerUs    = 4;
  localparam int swapCount     = 8;
  localparam int grayCount     = 8;
  localparam int patternLength = 24;
  localparam int maxDelayUs    = 20;
  localparam int quietCycles   = 100;
  // Reset, pixel ops, profiling, three delays, quiet window, then headroom
  localparam int watchdogCycles = 40 + (swapCount + grayCount + 2) * 4 + patternLength + 60
                                  + 3 * (maxDelayUs * ticksPerUs + 4) + quietCycles + 200;

  logic          s_systemClock;
  logic          s_pllLocked;
  logic          ciStart;
  ciPkg::ciIdT   ciN;
  ciPkg::ciDataT ciDataA;
  ciPkg::ciDataT ciDataB;
  logic          stall;
  logic          busIdle;
  logic          ciDone;
  ciPkg::ciDataT ciResult;
  logic          coreReady;

  int edgeCount;
  int lastStartEdge;
  int errorCount;
  int testErrors;
  int testCount;

  ciSubsystem #(
    .ticksPerMicrosecond(ticksPerUs)
  ) i_dut (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .stall        (stall),
    .busIdle      (busIdle),
    .ciDone       (ciDone),
    .ciResult     (ciResult),
    .coreReady    (coreReady)
  );

  always #(clockPeriod / 2) s_systemClock = ~s_systemClock;

  always @(posedge s_systemClock) begin
    edgeCount <= edgeCount + 1;  // Edge index for profiling math
  end

  function automatic ciPkg::ciDataT reverseBytes(input ciPkg::ciDataT word);
    ciPkg::ciDataT reversed;
    for (int b = 0; b < 4; b++) begin
      reversed[8*b +: 8] = word[8*(3-b) +: 8];
    end
    return reversed;
  endfunction

  // RGB565 to luma with weights 54, 183 and 19 out of 256
  function automatic ciPkg::ciDataT expectedGray(input logic [15:0] pixel);
    int red;
    int green;
    int blue;
    red   = int'(pixel[15:11]) * 8;
    green = int'(pixel[10:5]) * 4;
    blue  = int'(pixel[4:0]) * 8;
    return ciPkg::ciDataT'((red * 54 + green * 183 + blue * 19) / 256);
  endfunction

  task automatic checkValue(input string name, input ciPkg::ciDataT expected,
                            input ciPkg::ciDataT actual);
    assert (actual == expected) else begin
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
      testErrors++;
    end
  endtask

  task automatic finishTest(input string name);
    testCount++;
    errorCount += testErrors;
    if (testErrors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, testErrors);
    end
    testErrors = 0;
  endtask

  // One-cycle start, then wait for done at falling edges
  task automatic runInstruction(input ciPkg::ciIdT id, input ciPkg::ciDataT a,
                                input ciPkg::ciDataT b, input int limit,
                                output ciPkg::ciDataT result, output int latency);
    bit gotDone;
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN     <= id;
    ciDataA <= a;
    ciDataB <= b;
    @(posedge s_systemClock);
    ciStart <= 1'b0;
    lastStartEdge = edgeCount;
    latency = 1;
    gotDone = 1'b0;
    result  = '0;
    while (!gotDone && latency <= limit) begin
      @(negedge s_systemClock);
      if (ciDone) begin
        gotDone = 1'b1;
        result  = ciResult;
      end else begin
        @(posedge s_systemClock);
        latency++;
      end
    end
    if (!gotDone) begin
      $display("instruction %0d got no done within %0d cycles", id, limit);
      testErrors++;
    end
  endtask

  task automatic measureResetStretch();
    int lockEdges;
    int earlyDones;
    lockEdges  = 0;
    earlyDones = 0;
    repeat (2) @(posedge s_systemClock);
    s_pllLocked <= 1'b1;
    ciDataA     <= $urandom();
    while (!coreReady && lockEdges < 40) begin
      @(posedge s_systemClock);
      lockEdges++;
      ciStart <= (lockEdges == 8);  // Swap start while the core is held
      @(negedge s_systemClock);
      if (ciDone) begin
        earlyDones++;
      end
    end
    checkValue("reset stretch cycles", 16, lockEdges);
    checkValue("reset early done", 0, earlyDones);
  endtask

  task automatic swapAndGrayscale();
    ciPkg::ciDataT word;
    ciPkg::ciDataT result;
    int latency;
    for (int i = 0; i < swapCount; i++) begin
      word = $urandom();
      runInstruction(ciPkg::ciSwapByte, word, $urandom(), 4, result, latency);
      checkValue("byteSwap result", reverseBytes(word), result);
      checkValue("byteSwap latency", 1, latency);
    end
    finishTest("byteSwap");
    for (int i = 0; i < grayCount + 2; i++) begin
      word = (i == 0) ? 32'h0000_ffff : (i == 1) ? 32'h0 : $urandom();
      runInstruction(ciPkg::ciGrayscale, word, 32'h0, 4, result, latency);
      checkValue("grayscale result", expectedGray(word[15:0]), result);
      checkValue("grayscale latency", 1, latency);
    end
  endtask

  task automatic exerciseCounters();
    ciPkg::ciDataT result;
    int latency;
    int enableEdge;
    int clearEdge;
    int stallHigh;
    bit stallBit;
    // Clear all counters, enable cycle and stall
    runInstruction(ciPkg::ciProfile, 32'h0, 32'h0000_0f03, 4, result, latency);
    enableEdge = lastStartEdge;
    checkValue("profile latency", 1, latency);
    stallHigh = 0;
    for (int i = 0; i < patternLength; i++) begin
      @(posedge s_systemClock);
      stallBit = 1'($urandom());
      stall   <= stallBit;
      busIdle <= 1'($urandom());
      if (stallBit) begin
        stallHigh++;
      end
    end
    @(posedge s_systemClock);
    stall   <= 1'b0;
    busIdle <= 1'b0;
    runInstruction(ciPkg::ciProfile, ciPkg::ciDataT'(ciPkg::cntCycle), 32'h0, 4, result, latency);
    checkValue("profile cycles", lastStartEdge - enableEdge - 1, result);
    runInstruction(ciPkg::ciProfile, ciPkg::ciDataT'(ciPkg::cntStall), 32'h0, 4, result, latency);
    checkValue("profile stalls", stallHigh, result);
    runInstruction(ciPkg::ciProfile, ciPkg::ciDataT'(ciPkg::cntBusIdle), 32'h0, 4, result,
                   latency);
    checkValue("profile busIdle disabled", 0, result);
    runInstruction(ciPkg::ciProfile, ciPkg::ciDataT'(ciPkg::cntStallIdle), 32'h0, 4, result,
                   latency);
    checkValue("profile stallIdle disabled", 0, result);
    // Read returns the pre-clear value
    runInstruction(ciPkg::ciProfile, ciPkg::ciDataT'(ciPkg::cntStall), 32'h200, 4, result,
                   latency);
    checkValue("profile stalls at clear", stallHigh, result);
    // Read the cleared stall counter and disable it
    runInstruction(ciPkg::ciProfile, ciPkg::ciDataT'(ciPkg::cntStall), 32'h20, 4, result,
                   latency);
    checkValue("profile stalls cleared", 0, result);
    repeat (4) begin
      @(posedge s_systemClock);
      stall <= 1'b1;
    end
    @(posedge s_systemClock);
    stall <= 1'b0;
    runInstruction(ciPkg::ciProfile, ciPkg::ciDataT'(ciPkg::cntStall), 32'h0, 4, result, latency);
    checkValue("profile stalls after disable", 0, result);
    // Clear the running cycle counter
    runInstruction(ciPkg::ciProfile, ciPkg::ciDataT'(ciPkg::cntCycle), 32'h100, 4, result,
                   latency);
    clearEdge = lastStartEdge;
    runInstruction(ciPkg::ciProfile, ciPkg::ciDataT'(ciPkg::cntCycle), 32'h0, 4, result, latency);
    checkValue("profile cycles after clear", lastStartEdge - clearEdge - 1, result);
  endtask

  task automatic timeDelays();
    int delays[3];
    ciPkg::ciDataT result;
    int latency;
    delays[0] = 0;
    delays[1] = 1;
    delays[2] = int'($urandom_range(maxDelayUs, 2));
    for (int i = 0; i < 3; i++) begin
      runInstruction(ciPkg::ciDelay, delays[i], $urandom(), delays[i] * ticksPerUs + 10,
                     result, latency);
      checkValue("delay latency", delays[i] * ticksPerUs + 2, latency);
      checkValue("delay result", 0, result);
    end
  endtask

  task automatic probeUnclaimedId();
    int doneCount;
    doneCount = 0;
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN     <= ciPkg::ciIdT'(8'd3);
    ciDataA <= $urandom();
    @(posedge s_systemClock);
    ciStart <= 1'b0;
    repeat (quietCycles) begin
      @(negedge s_systemClock);
      if (ciDone) begin
        doneCount++;
      end
    end
    checkValue("unclaimed done count", 0, doneCount);
  endtask

  initial begin
    void'($urandom(32'h3d95));
    s_systemClock = 1'b0;
    s_pllLocked   = 1'b0;
    ciStart       = 1'b0;
    ciN           = ciPkg::ciSwapByte;
    ciDataA       = '0;
    ciDataB       = '0;
    stall         = 1'b0;
    busIdle       = 1'b0;
    edgeCount     = 0;
    errorCount    = 0;
    testErrors    = 0;
    testCount     = 0;
    measureResetStretch();
    finishTest("reset");
    swapAndGrayscale();
    finishTest("grayscale");
    exerciseCounters();
    finishTest("profile");
    timeDelays();
    finishTest("delay");
    probeUnclaimedId();
    finishTest("unclaimed");
    $display("summary: %0d tests, %0d check errors, %0d assertion failures", testCount,
             errorCount, i_dut.protocolMonitor.assertFailures);
    if (errorCount == 0 && i_dut.protocolMonitor.assertFailures == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(watchdogCycles * clockPeriod);
    $display("watchdog: run did not finish within %0d cycles", watchdogCycles);
    $display("tests failed");
    $finish;
  end

endmodule

// File: sim/ciSubsystem_checker.sv
module ciSubsystem_checker #(
  parameter int ticksPerMicrosecond = 4
) (
  input logic          s_systemClock,
  input logic          s_pllLocked,
  input logic          ciStart,
  input ciPkg::ciIdT   ciN,
  input ciPkg::ciDataT ciDataA,
  input logic          ciDone,
  input ciPkg::ciDataT ciResult,
  input logic          coreReady
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int stretchCycles = 16;

  int   lockCycles;
  logic delayPending;
  int   delayElapsed;
  int   delayTarget;
  int   readyFailures = 0;
  int   quietFailures = 0;
  int   resultFailures = 0;
  int   pulseFailures = 0;
  int   latencyFailures = 0;
  int   lateFailures = 0;
  int   assertFailures;

  // Cycles seen with the PLL locked, saturating at the stretch
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      lockCycles <= 0;
    end else if (lockCycles < stretchCycles) begin
      lockCycles <= lockCycles + 1;
    end
  end

  // Expected latency of the delay instruction in flight
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      delayPending <= 1'b0;
      delayElapsed <= 0;
      delayTarget  <= 0;
    end else if (ciStart && ciN == ciPkg::ciDelay && coreReady) begin
      delayPending <= 1'b1;
      delayElapsed <= 1;
      delayTarget  <= int'(ciDataA) * ticksPerMicrosecond + 2;
    end else if (delayPending) begin
      if (ciDone) begin
        delayPending <= 1'b0;
      end
      delayElapsed <= delayElapsed + 1;
    end
  end

  readyAfterStretch: assert property (@(posedge s_systemClock)
    coreReady == (lockCycles >= stretchCycles))
    else begin
      readyFailures++;
      $error("coreReady does not follow the 16 cycle stretch after PLL lock");
    end

  noDoneBeforeReady: assert property (@(posedge s_systemClock) !coreReady |-> !ciDone)
    else begin
      quietFailures++;
      $error("done raised while the core is still held in reset");
    end

  resultZeroWhenIdle: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    !ciDone |-> ciResult == '0)
    else begin
      resultFailures++;
      $error("result is not zero while done is low");
    end

  doneSinglePulse: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    ciDone |=> !ciDone)
    else begin
      pulseFailures++;
      $error("done stayed high for more than one cycle");
    end

  delayLatency: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    (delayPending && ciDone) |-> delayElapsed == delayTarget)
    else begin
      latencyFailures++;
      $error("delay done after %0d cycles, expected %0d", delayElapsed, delayTarget);
    end

  delayNotLate: assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    delayPending |-> delayElapsed <= delayTarget)
    else begin
      lateFailures++;
      $error("delay done missing after %0d cycles", delayElapsed);
    end

  assign assertFailures = readyFailures + quietFailures + resultFailures + pulseFailures
                          + latencyFailures + lateFailures;

endmodule

bind ciSubsystem ciSubsystem_checker #(
  .ticksPerMicrosecond(ticksPerMicrosecond)
) protocolMonitor (
  .s_systemClock(s_systemClock),
  .s_pllLocked  (s_pllLocked),
  .ciStart      (ciStart),
  .ciN          (ciN),
  .ciDataA      (ciDataA),
  .ciDone       (ciDone),
  .ciResult     (ciResult),
  .coreReady    (coreReady)
);

// File: hw/ciSubsystem.sv
module ciSubsystem #(
  parameter int ticksPerMicrosecond = 4
) (
  input  logic          s_systemClock,
  input  logic          s_pllLocked,
  input  logic          ciStart,
  input  ciPkg::ciIdT   ciN,
  input  ciPkg::ciDataT ciDataA,
  input  ciPkg::ciDataT ciDataB,
  input  logic          stall,
  input  logic          busIdle,
  output logic          ciDone,
  output ciPkg::ciDataT ciResult,
  output logic          coreReady
);

  logic          coreReset;
  logic          pixelDone;
  logic          profileDone;
  logic          delayDone;
  ciPkg::ciDataT pixelResult;
  ciPkg::ciDataT profileResult;
  ciPkg::ciDataT delayResult;

  resetSequencer resetSeq (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .coreReset    (coreReset),
    .coreReady    (coreReady)
  );

  pixelCi #(
    .swapId(ciPkg::ciSwapByte),
    .grayId(ciPkg::ciGrayscale)
  ) pixel (
    .s_systemClock(s_systemClock),
    .coreReset    (coreReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDone       (pixelDone),
    .ciResult     (pixelResult)
  );

  profileCounters #(
    .profileId(ciPkg::ciProfile)
  ) profile (
    .s_systemClock(s_systemClock),
    .coreReset    (coreReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .stall        (stall),
    .busIdle      (busIdle),
    .ciDone       (profileDone),
    .ciResult     (profileResult)
  );

  delayCi #(
    .delayId            (ciPkg::ciDelay),
    .ticksPerMicrosecond(ticksPerMicrosecond)
  ) delayMicro (
    .s_systemClock(s_systemClock),
    .coreReset    (coreReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDone       (delayDone),
    .ciResult     (delayResult)
  );

  // Idle units drive zero, so plain OR merges them
  assign ciDone   = pixelDone | profileDone | delayDone;
  assign ciResult = pixelResult | profileResult | delayResult;

endmodule

// File: hw/delayCi.sv
module delayCi #(
  parameter ciPkg::ciIdT delayId             = ciPkg::ciDelay,
  parameter int          ticksPerMicrosecond = 4
) (
  input  logic          s_systemClock,
  input  logic          coreReset,
  input  logic          ciStart,
  input  ciPkg::ciIdT   ciN,
  input  ciPkg::ciDataT ciDataA,
  output logic          ciDone,
  output ciPkg::ciDataT ciResult
);

  localparam int tickWidth = $clog2(ticksPerMicrosecond + 1);
  localparam logic [tickWidth-1:0] tickReload = tickWidth'(ticksPerMicrosecond - 1);

  ciPkg::delayStateT    delayState;
  ciPkg::ciDataT        usCount;
  logic [tickWidth-1:0] tickCount;
  logic                 isDelay;
  logic                 countDone;

  assign isDelay   = ciStart && (ciN == delayId);
  assign countDone = (usCount == '0) && (tickCount == '0);

  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      delayState <= ciPkg::delayIdle;
    end else begin
      case (delayState)
        ciPkg::delayIdle: begin
          if (isDelay) begin
            delayState <= ciPkg::delayCounting;
          end
        end
        ciPkg::delayCounting: begin
          if (countDone) begin
            delayState <= ciPkg::delayFinished;
          end
        end
        default: delayState <= ciPkg::delayIdle;  // Finished lasts one cycle
      endcase
    end
  end

  // Each microsecond takes one reload plus tickReload down-counts
  always_ff @(posedge s_systemClock) begin
    if (isDelay && delayState == ciPkg::delayIdle) begin
      usCount   <= ciDataA;
      tickCount <= '0;
    end else if (tickCount != '0) begin
      tickCount <= tickCount - 1'b1;
    end else if (usCount != '0) begin
      usCount   <= usCount - 1'b1;
      tickCount <= tickReload;
    end
  end

  assign ciDone   = (delayState == ciPkg::delayFinished);
  assign ciResult = '0;  // Delay returns nothing

endmodule

// File: hw/profileCounters.sv
module profileCounters #(
  parameter ciPkg::ciIdT profileId = ciPkg::ciProfile
) (
  input  logic          s_systemClock,
  input  logic          coreReset,
  input  logic          ciStart,
  input  ciPkg::ciIdT   ciN,
  input  ciPkg::ciDataT ciDataA,
  input  ciPkg::ciDataT ciDataB,
  input  logic          stall,
  input  logic          busIdle,
  output logic          ciDone,
  output ciPkg::ciDataT ciResult
);

  localparam int numCounters = 4;

  ciPkg::ciDataT     counters [numCounters];
  logic [3:0]        enabled;
  logic [3:0]        countCond;
  logic              isProfile;
  ciPkg::counterSelT readSel;

  assign isProfile = ciStart && (ciN == profileId);
  assign readSel   = ciPkg::counterSelT'(ciDataA[1:0]);

  // What each counter counts
  always_comb begin
    countCond[ciPkg::cntCycle]     = 1'b1;
    countCond[ciPkg::cntStall]     = stall;
    countCond[ciPkg::cntBusIdle]   = busIdle;
    countCond[ciPkg::cntStallIdle] = stall & busIdle;
  end

  // DataB[3:0] enables, DataB[7:4] disables
  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      enabled <= '0;
    end else if (isProfile) begin
      enabled <= (enabled | ciDataB[3:0]) & ~ciDataB[7:4];
    end
  end

  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      for (int i = 0; i < numCounters; i++) begin
        counters[i] <= '0;
      end
    end else begin
      for (int i = 0; i < numCounters; i++) begin
        if (isProfile && ciDataB[8 + i]) begin
          counters[i] <= '0;  // Clear beats count
        end else if (enabled[i] && countCond[i]) begin
          counters[i] <= counters[i] + 1'b1;
        end
      end
    end
  end

  // Value captured at the start edge, before any clear
  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      ciDone   <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone   <= isProfile;
      ciResult <= isProfile ? counters[readSel] : '0;
    end
  end

endmodule

// File: hw/pixelCi.sv
module pixelCi #(
  parameter ciPkg::ciIdT swapId = ciPkg::ciSwapByte,
  parameter ciPkg::ciIdT grayId = ciPkg::ciGrayscale
) (
  input  logic          s_systemClock,
  input  logic          coreReset,
  input  logic          ciStart,
  input  ciPkg::ciIdT   ciN,
  input  ciPkg::ciDataT ciDataA,
  output logic          ciDone,
  output ciPkg::ciDataT ciResult
);

  logic          isSwap;
  logic          isGray;
  logic [15:0]   red;
  logic [15:0]   green;
  logic [15:0]   blue;
  logic [15:0]   weightedSum;
  ciPkg::ciDataT swapped;
  ciPkg::ciDataT grayWord;
  ciPkg::ciDataT nextResult;

  assign isSwap = ciStart && (ciN == swapId);
  assign isGray = ciStart && (ciN == grayId);

  assign swapped = {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};

  // RGB565 fields widened to 8 bits each
  assign red   = {8'd0, ciDataA[15:11], 3'b000};
  assign green = {8'd0, ciDataA[10:5], 2'b00};
  assign blue  = {8'd0, ciDataA[4:0], 3'b000};

  // Weights sum to 256, so the high byte is the luma
  assign weightedSum = red * 16'd54 + green * 16'd183 + blue * 16'd19;
  assign grayWord    = {24'd0, weightedSum[15:8]};

  always_comb begin
    nextResult = '0;  // Keeps the OR bus clean
    if (isSwap) begin
      nextResult = swapped;
    end else if (isGray) begin
      nextResult = grayWord;
    end
  end

  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      ciDone   <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone   <= isSwap | isGray;
      ciResult <= nextResult;
    end
  end

endmodule

// File: hw/resetSequencer.sv
module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic coreReset,
  output logic coreReady
);

  localparam int topBit = ciPkg::resetCountWidth - 1;

  logic [ciPkg::resetCountWidth-1:0] resetCount;

  // Counts up after lock, then holds once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[topBit]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign coreReset = ~resetCount[topBit];
  assign coreReady = resetCount[topBit];  // Core released

endmodule

// File: hw/ciPkg.sv
package ciPkg;

  // Custom instruction numbers as seen on ciN
  typedef enum logic [7:0] {
    ciSwapByte  = 8'd1,
    ciDelay     = 8'd6,
    ciProfile   = 8'd8,
    ciGrayscale = 8'd12
  } ciIdT;

  // Operand and result word of the custom-instruction port
  typedef logic [31:0] ciDataT;

  // Profiling counter index, selected through DataA[1:0]
  typedef enum logic [1:0] {
    cntCycle     = 2'd0,
    cntStall     = 2'd1,
    cntBusIdle   = 2'd2,
    cntStallIdle = 2'd3
  } counterSelT;

  typedef enum logic [1:0] {
    delayIdle     = 2'd0,
    delayCounting = 2'd1,
    delayFinished = 2'd2
  } delayStateT;

  // Top bit releases the core, so 16 cycles of stretch
  localparam int resetCountWidth = 5;

endpackage
